//--- Makefile
# Verilator build and run for the core monitor testbench
SIM := obj_dir/VcoreMonitorTb

$(SIM): coreMonitor.f verilog/*.sv verilog/*.svh test/*.sv test/*.svh
	verilator --binary --timing --top-module coreMonitorTb -f coreMonitor.f -o VcoreMonitorTb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- coreMonitor.f
+incdir+verilog
+incdir+test
verilog/coreMonPkg.sv
verilog/monCtrlIf.sv
verilog/apbFlagRegs.sv
verilog/resetControl.sv
verilog/pcMonitor.sv
verilog/coreMonitorTop.sv
test/coreMonitorTb.sv

//--- test/tbChecks.svh
// APB transfer task, LFSR random bits and typed compare tasks for the testbench
`ifndef TBCHECKS_SVH
`define TBCHECKS_SVH

  // ------------------------------------------------------------
  // APB master
  // ------------------------------------------------------------
  // Setup and access cycles entered and left 1 ns past a rising edge
  task automatic apbXfer(input logic write, input logic [`CM_ADDR_W-1:0] addr,
                         input logic [`CM_DATA_W-1:0] wdata,
                         output logic [`CM_DATA_W-1:0] rdata, output logic slvErr);
    pAddr   = addr;
    pWrite  = write;
    pWData  = wdata;
    pSel    = 1'b1;
    pEnable = 1'b0;
    @(posedge dvtFlags);
    #1;
    pEnable = 1'b1;
    @(negedge dvtFlags);                       // Mid access cycle
    rdata  = pRData;
    slvErr = pSlvErr;
    checkBit("pReady", 1'b1, pReady);          // No wait states
    @(posedge dvtFlags);
    #1;
    pSel    = 1'b0;
    pEnable = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Random bits
  // ------------------------------------------------------------
  function automatic logic lfsrBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ 32'hA300_0000;   // Taps 32, 30, 26, 25
    return outBit;
  endfunction

  function automatic logic [31:0] randWord(input int nBits);
    logic [31:0] w;
    int          i;
    w = '0;
    for (i = 0; i < nBits; i++)
      w = {w[30:0], lfsrBit()};
    return w;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic checkStatus(input coreMonPkg::statusT expVal,
                             input coreMonPkg::statusT actVal);
    if (actVal !== expVal)
      abortRun($sformatf("Fail at %0t ns: STATUS expected %06b, got %06b",
                         $time, expVal, actVal));
  endtask

  task automatic checkData(input string name, input logic [`CM_DATA_W-1:0] expVal,
                           input logic [`CM_DATA_W-1:0] actVal);
    if (actVal !== expVal)
      abortRun($sformatf("Fail at %0t ns: %s expected %h, got %h",
                         $time, name, expVal, actVal));
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal)
      abortRun($sformatf("Fail at %0t ns: %s expected %b, got %b",
                         $time, name, expVal, actVal));
  endtask

`endif

//--- test/coreMonitorTb.sv
// Core monitor testbench: clock, reset, watchdog, stimulus file player and DUT
`timescale 1ns/1ps
`include "coreMon_macros.svh"

module coreMonitorTb;

  logic                  dvtFlags;
  logic                  pcFail;
  logic [`CM_ADDR_W-1:0] pAddr;
  logic                  pSel;
  logic                  pEnable;
  logic                  pWrite;
  logic [`CM_DATA_W-1:0] pWData;
  logic [`CM_DATA_W-1:0] pRData;
  logic                  pReady;
  logic                  pSlvErr;
  logic [`CM_PC_W-1:0]   pcValue;
  logic                  pcValid;
  logic                  programLoaded;
  logic                  tileReset;
  logic                  coreReset;

  logic [31:0] lfsrState;
  byte         opList[$];
  logic [31:0] argA[$];             // Address, PC or bit select
  logic [31:0] argD[$];             // Data, count or mask
  logic [31:0] argE[$];             // Expected value
  logic        stimLoaded;

  coreMonitorTop #(.coreId(2)) dut_i (
    .dvtFlags     (dvtFlags),
    .pcFail       (pcFail),
    .pAddr        (pAddr),
    .pSel         (pSel),
    .pEnable      (pEnable),
    .pWrite       (pWrite),
    .pWData       (pWData),
    .pRData       (pRData),
    .pReady       (pReady),
    .pSlvErr      (pSlvErr),
    .pcValue      (pcValue),
    .pcValid      (pcValid),
    .programLoaded(programLoaded),
    .tileReset    (tileReset),
    .coreReset    (coreReset)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Run stopped");
  endtask

  `include "tbChecks.svh"

  initial begin
    dvtFlags = 1'b0;
    forever #4 dvtFlags = ~dvtFlags;       // 8 ns period
  end

  // Watchdog sized from the stimulus length
  initial begin
    wait (stimLoaded);
    repeat (opList.size() * 600 + 100) @(posedge dvtFlags);
    abortRun("Timeout: the run did not finish within the expected number of cycles");
  end

  task automatic applyReset();
    pcFail = 1'b1;
    repeat (2) @(posedge dvtFlags);
    #1;
    pcFail = 1'b0;
  endtask

  task automatic drivePc(input logic [`CM_PC_W-1:0] pc, input logic [31:0] cycles);
    pcValue = pc;
    pcValid = 1'b1;
    repeat (cycles) begin
      @(posedge dvtFlags);
      #1;
    end
    pcValid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // One stimulus line
  // ------------------------------------------------------------
  task automatic runOp(input byte op, input logic [31:0] a, input logic [31:0] d,
                       input logic [31:0] e);
    logic [`CM_DATA_W-1:0] rd;
    logic [`CM_DATA_W-1:0] wd;
    logic                  err;
    int                    cnt;
    case (op)
      "W": apbXfer(1'b1, a[`CM_ADDR_W-1:0], d, rd, err);
      "R": begin
        apbXfer(1'b0, a[`CM_ADDR_W-1:0], '0, rd, err);
        checkBit("pSlvErr", 1'b0, err);
        checkData("pRData", e, rd);
      end
      "S": begin
        apbXfer(1'b0, `CM_REG_STATUS, '0, rd, err);
        checkStatus(coreMonPkg::statusT'(e[5:0]), coreMonPkg::statusT'(rd[5:0]));
      end
      "E": begin                            // Unmapped address
        apbXfer(1'b0, a[`CM_ADDR_W-1:0], '0, rd, err);
        checkBit("pSlvErr", 1'b1, err);
        checkData("pRData", '0, rd);
      end
      "L": begin
        wd = randWord(32);
        apbXfer(1'b1, a[`CM_ADDR_W-1:0], wd, rd, err);
        apbXfer(1'b0, a[`CM_ADDR_W-1:0], '0, rd, err);
        checkData("pRData", wd & d, rd);  // Only implemented bits stick
      end
      "P": drivePc(a, d);
      "N": repeat (d) drivePc(randWord(31) | 32'h8000_0000, 1);
      "B": begin
        repeat (d) begin
          @(posedge dvtFlags);
          #1;
        end
        if (a[0])
          checkBit("coreReset", e[0], coreReset);
        else
          checkBit("tileReset", e[0], tileReset);
      end
      "C": begin                            // Cycles from detection edge to core reset
        cnt = 0;
        while (coreReset !== 1'b1 && cnt <= e) begin
          @(posedge dvtFlags);
          #1;
          cnt++;
        end
        checkData("cycles to coreReset", e, cnt);
      end
      "G": programLoaded = d[0];
      "X": applyReset();
      default: abortRun($sformatf("Unknown stimulus operation '%c'", op));
    endcase
  endtask

  initial begin
    int          fd;
    int          i;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;

    pcFail        = 1'b1;
    pAddr         = '0;
    pSel          = 1'b0;
    pEnable       = 1'b0;
    pWrite        = 1'b0;
    pWData        = '0;
    pcValue       = '0;
    pcValid       = 1'b0;
    programLoaded = 1'b0;
    lfsrState     = 32'hb764;
    stimLoaded    = 1'b0;

    fd = $fopen("test/coreMonitor_stim.txt", "r");
    if (fd == 0)
      abortRun("Could not open the stimulus file test/coreMonitor_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != 8'h23) begin   // Skip # lines
        if ($sscanf(line, "%c %h %h %h", op, a, d, e) != 4)
          abortRun({"Malformed stimulus line: ", line});
        opList.push_back(op);
        argA.push_back(a);
        argD.push_back(d);
        argE.push_back(e);
      end
    end
    $fclose(fd);
    stimLoaded = 1'b1;

    applyReset();
    for (i = 0; i < opList.size(); i++)
      runOp(opList[i], argA[i], argD[i], argE[i]);
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- test/coreMonitor_stim.txt
# op addr/pc/sel data/count/mask expected, all hex
# W wr R rd S status E badaddr L randwr P pc N filler B rstbit C rstdelay G progld X reset
S 00 0 04
L 10 ffffffff 0
L 20 ffffffff 0
L 00 f 0
L 0c 3 0
E 24 0 0
W 00 1 0
W 04 6 0
B 0 2 1
B 1 0 0
W 00 2 0
R 00 0 2
W 04 2 0
B 0 2 0
W 04 4 0
B 1 2 1
S 00 0 08
R 04 0 0
X 0 0 0
W 10 1000 0
W 14 2000 0
W 18 3000 0
W 1c 4000 0
W 20 5000 0
W 0c 1 0
N 0 8 0
P 4000 1 0
S 00 0 04
P 1000 1 0
C 0 0 14
S 00 0 0d
X 0 0 0
W 1c 4000 0
W 0c 3 0
P 4000 1 0
S 00 0 05
W 00 2 0
W 04 20 0
S 00 0 06
X 0 0 0
W 14 2000 0
W 0c 1 0
P 2000 1 0
S 00 0 06
X 0 0 0
P 1234 1 0
S 00 0 06
X 0 0 0
W 10 1000 0
W 0c 1 0
P 7777 1f3 0
S 00 0 04
P 7777 1 0
C 0 0 14
S 00 0 0e
X 0 0 0
W 00 2 0
W 04 10 0
W 10 1000 0
W 0c 1 0
P 7777 1f4 0
S 00 0 24
P 1000 1 0
B 1 1e 0
S 00 0 25
G 0 1 0
S 00 0 35

//--- verilog/apbFlagRegs.sv
// APB register slave: pattern, command pulses, status readback, config and PC table
`timescale 1ns/1ps
`include "coreMon_macros.svh"

module apbFlagRegs #(
  parameter int unsigned coreId = 0
) (
  input  logic                  dvtFlags,
  input  logic                  pcFail,
  input  logic [`CM_ADDR_W-1:0] pAddr,
  input  logic                  pSel,
  input  logic                  pEnable,
  input  logic                  pWrite,
  input  logic [`CM_DATA_W-1:0] pWData,
  output logic [`CM_DATA_W-1:0] pRData,
  output logic                  pReady,
  output logic                  pSlvErr,
  input  logic                  programLoaded,
  monCtrlIf.regs                ctrl
);

  localparam logic [`CM_PAT_W-1:0] myPattern = `CM_PAT_W'(coreId);

  logic [`CM_PAT_W-1:0]  patternReg;
  logic [1:0]            configReg;    // {hostPass, tableValid}
  coreMonPkg::pfTableT   pfTableReg;
  coreMonPkg::cmdT       cmdReg;
  coreMonPkg::statusT    statusWord;
  logic [`CM_DATA_W-1:0] rdData;
  logic                  addrHit;
  logic                  access;
  logic                  wrEn;
  logic                  coreSelected;

  // ------------------------------------------------------------
  // Transfer decode
  // ------------------------------------------------------------
  assign access       = pSel & pEnable;
  assign wrEn         = access & pWrite & addrHit;
  assign coreSelected = (patternReg == myPattern);

  assign pReady  = 1'b1;                        // No wait states
  assign pSlvErr = access & ~addrHit;
  assign pRData  = (access & ~pWrite) ? rdData : '0;

  always_comb begin
    statusWord.passStatus    = ctrl.passStatus;
    statusWord.failStatus    = ctrl.failStatus;
    statusWord.tileReset     = ctrl.tileReset;
    statusWord.coreReset     = ctrl.coreReset;
    statusWord.programLoaded = programLoaded;
    statusWord.stuckDisabled = ctrl.stuckDisabled;
  end

  // Read mux, also flags the mapped addresses
  always_comb begin
    rdData  = '0;
    addrHit = 1'b1;
    case (pAddr)
      coreMonPkg::regPattern: rdData = `CM_DATA_W'(patternReg);
      coreMonPkg::regCmd:     rdData = '0;       // Commands self-clear
      coreMonPkg::regStatus:  rdData = `CM_DATA_W'(statusWord);
      coreMonPkg::regConfig:  rdData = `CM_DATA_W'(configReg);
      coreMonPkg::regPf0:     rdData = pfTableReg[0];
      coreMonPkg::regPf1:     rdData = pfTableReg[1];
      coreMonPkg::regPf2:     rdData = pfTableReg[2];
      coreMonPkg::regPf3:     rdData = pfTableReg[3];
      coreMonPkg::regPf4:     rdData = pfTableReg[4];
      default:                addrHit = 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      patternReg <= '0;
      configReg  <= '0;
      pfTableReg <= '0;
    end else if (wrEn) begin
      case (pAddr)
        coreMonPkg::regPattern: patternReg <= pWData[`CM_PAT_W-1:0];
        coreMonPkg::regConfig:  configReg  <= pWData[1:0];
        coreMonPkg::regPf0:     pfTableReg[0] <= pWData;
        coreMonPkg::regPf1:     pfTableReg[1] <= pWData;
        coreMonPkg::regPf2:     pfTableReg[2] <= pWData;
        coreMonPkg::regPf3:     pfTableReg[3] <= pWData;
        coreMonPkg::regPf4:     pfTableReg[4] <= pWData;
        default: ;
      endcase
    end
  end

  // Command pulses live for the one cycle after the access edge
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      cmdReg <= '0;
    end else if (wrEn && pAddr == coreMonPkg::regCmd && coreSelected) begin
      cmdReg <= coreMonPkg::cmdT'(pWData[$bits(coreMonPkg::cmdT)-1:0]);
    end else begin
      cmdReg <= '0;
    end
  end

  assign ctrl.cmd        = cmdReg;
  assign ctrl.pfTable    = pfTableReg;
  assign ctrl.tableValid = configReg[0];
  assign ctrl.hostPass   = configReg[1];

endmodule

//--- verilog/coreMonPkg.sv
// Core monitor types: command pulses, status word, PC table, slot kinds, register map
`include "coreMon_macros.svh"

package coreMonPkg;

  // CMD register bits, bit 0 at the bottom
  typedef struct packed {
    logic setFail;       // bit 5
    logic disableStuck;  // bit 4
    logic releaseCore;   // bit 3
    logic forceCore;     // bit 2
    logic releaseTile;   // bit 1
    logic forceTile;     // bit 0
  } cmdT;

  // STATUS register bits
  typedef struct packed {
    logic stuckDisabled; // bit 5
    logic programLoaded; // bit 4
    logic coreReset;     // bit 3
    logic tileReset;     // bit 2
    logic failStatus;    // bit 1
    logic passStatus;    // bit 0
  } statusT;

  typedef logic [`CM_PC_W-1:0] pcT;

  typedef pcT [`CM_NUM_PF-1:0] pfTableT;

  // Meaning of each pass/fail table slot
  typedef enum logic [2:0] {
    passA       = 3'd0,
    fail        = 3'd1,
    passB       = 3'd2,
    writeToHost = 3'd3,
    hang        = 3'd4
  } pfKindE;

  typedef enum logic [`CM_ADDR_W-1:0] {
    regPattern = `CM_REG_PATTERN,
    regCmd     = `CM_REG_CMD,
    regStatus  = `CM_REG_STATUS,
    regConfig  = `CM_REG_CONFIG,
    regPf0     = `CM_REG_PF0,
    regPf1     = `CM_REG_PF1,
    regPf2     = `CM_REG_PF2,
    regPf3     = `CM_REG_PF3,
    regPf4     = `CM_REG_PF4
  } regAddrE;

endpackage

//--- verilog/coreMon_macros.svh
// Core monitor constants: bus widths, register map, stuck limit and sleep delay
`ifndef COREMON_MACROS_SVH
`define COREMON_MACROS_SVH

// ------------------------------------------------------------
// Bus and datapath widths
// ------------------------------------------------------------
`define CM_ADDR_W       8
`define CM_DATA_W       32
`define CM_PC_W         32
`define CM_PAT_W        4     // Core-select pattern

// ------------------------------------------------------------
// PC monitor tuning
// ------------------------------------------------------------
`define CM_STUCK_LIMIT  500   // Repeated valid PCs before stuck
`define CM_SLEEP_DELAY  20    // Detection to core reset, in cycles
`define CM_NUM_PF       5     // Pass/fail table slots

// ------------------------------------------------------------
// APB register map (byte addresses)
// ------------------------------------------------------------
`define CM_REG_PATTERN  8'h00
`define CM_REG_CMD      8'h04
`define CM_REG_STATUS   8'h08
`define CM_REG_CONFIG   8'h0C
`define CM_REG_PF0      8'h10
`define CM_REG_PF1      8'h14
`define CM_REG_PF2      8'h18
`define CM_REG_PF3      8'h1C
`define CM_REG_PF4      8'h20

`endif

//--- verilog/coreMonitorTop.sv
// Per-core monitor top: APB and core ports, control interface and block instances
`timescale 1ns/1ps
`include "coreMon_macros.svh"

module coreMonitorTop #(
  parameter int unsigned coreId = 0
) (
  input  logic                  dvtFlags,
  input  logic                  pcFail,
  // APB slave
  input  logic [`CM_ADDR_W-1:0] pAddr,
  input  logic                  pSel,
  input  logic                  pEnable,
  input  logic                  pWrite,
  input  logic [`CM_DATA_W-1:0] pWData,
  output logic [`CM_DATA_W-1:0] pRData,
  output logic                  pReady,
  output logic                  pSlvErr,
  // Core side
  input  logic [`CM_PC_W-1:0]   pcValue,
  input  logic                  pcValid,
  input  logic                  programLoaded,
  output logic                  tileReset,
  output logic                  coreReset
);

  monCtrlIf ctrlIf ();

  apbFlagRegs #(.coreId(coreId)) regs_i (
    .dvtFlags     (dvtFlags),
    .pcFail       (pcFail),
    .pAddr        (pAddr),
    .pSel         (pSel),
    .pEnable      (pEnable),
    .pWrite       (pWrite),
    .pWData       (pWData),
    .pRData       (pRData),
    .pReady       (pReady),
    .pSlvErr      (pSlvErr),
    .programLoaded(programLoaded),
    .ctrl         (ctrlIf.regs)
  );

  resetControl rst_i (
    .dvtFlags(dvtFlags),
    .pcFail  (pcFail),
    .ctrl    (ctrlIf.rst)
  );

  pcMonitor mon_i (
    .dvtFlags(dvtFlags),
    .pcFail  (pcFail),
    .pcValue (pcValue),
    .pcValid (pcValid),
    .ctrl    (ctrlIf.mon)
  );

  assign tileReset = ctrlIf.tileReset;
  assign coreReset = ctrlIf.coreReset;

endmodule

//--- verilog/monCtrlIf.sv
// Control and status interface between register block, reset control and PC monitor
`timescale 1ns/1ps

interface monCtrlIf;

  coreMonPkg::cmdT     cmd;           // One-cycle command pulses
  coreMonPkg::pfTableT pfTable;
  logic                tableValid;
  logic                hostPass;      // Write-to-host counts as pass

  logic                tileReset;
  logic                coreReset;

  logic                passStatus;
  logic                failStatus;
  logic                stuckDisabled;
  logic                detectPulse;   // First pass or fail only

  modport regs (output cmd, pfTable, tableValid, hostPass,
                input  tileReset, coreReset, passStatus, failStatus, stuckDisabled);

  modport rst  (input  cmd, detectPulse, stuckDisabled,
                output tileReset, coreReset);

  modport mon  (input  cmd, pfTable, tableValid, hostPass, coreReset,
                output passStatus, failStatus, stuckDisabled, detectPulse);

endinterface

//--- verilog/pcMonitor.sv
// Stuck detection, pass/fail table match and sticky result of the PC monitor
`timescale 1ns/1ps
`include "coreMon_macros.svh"

module pcMonitor (
  input  logic            dvtFlags,
  input  logic            pcFail,
  input  coreMonPkg::pcT  pcValue,
  input  logic            pcValid,
  monCtrlIf.mon           ctrl
);

  localparam int stuckW = $clog2(`CM_STUCK_LIMIT + 1);
  localparam logic [stuckW-1:0] stuckMax = stuckW'(`CM_STUCK_LIMIT);

  coreMonPkg::pcT    lastPc;
  logic [stuckW-1:0] stuckCnt;     // Length of current run of equal PCs
  logic              sample;
  logic              samePc;
  logic              stuckHit;
  logic              pcPass;
  logic              pcHitFail;
  logic              detect;
  logic              passReg;
  logic              failReg;
  logic              disableReg;
  logic              detectReg;

  assign sample   = pcValid & ~ctrl.coreReset;
  assign samePc   = (pcValue == lastPc);
  assign stuckHit = sample & samePc & (stuckCnt == stuckMax - 1'b1);

  // ------------------------------------------------------------
  // Repeat counter
  // ------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      lastPc   <= '0;
      stuckCnt <= '0;
    end else if (sample) begin
      lastPc <= pcValue;
      if (!samePc)
        stuckCnt <= stuckW'(1);
      else if (stuckCnt != stuckMax)
        stuckCnt <= stuckCnt + 1'b1;          // Saturates at the limit
    end
  end

  // ------------------------------------------------------------
  // Table match
  // ------------------------------------------------------------
  always_comb begin
    pcPass    = 1'b0;
    pcHitFail = 1'b0;
    if (stuckHit && !disableReg) begin
      pcHitFail = 1'b1;
    end else if (sample) begin
      if (!ctrl.tableValid)
        pcHitFail = 1'b1;                       // No table loaded
      else if (pcValue == ctrl.pfTable[coreMonPkg::passA])
        pcPass = 1'b1;
      else if (pcValue == ctrl.pfTable[coreMonPkg::passB])
        pcPass = 1'b1;
      else if (pcValue == ctrl.pfTable[coreMonPkg::writeToHost])
        pcPass = ctrl.hostPass;
      else if (pcValue == ctrl.pfTable[coreMonPkg::hang])
        pcHitFail = 1'b1;
      else if (pcValue == ctrl.pfTable[coreMonPkg::fail])
        pcHitFail = 1'b1;
    end
  end

  // Only the first result counts
  assign detect = (pcPass | pcHitFail) & ~(passReg | failReg);

  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      passReg    <= 1'b0;
      failReg    <= 1'b0;
      disableReg <= 1'b0;
      detectReg  <= 1'b0;
    end else begin
      detectReg <= detect;
      if (ctrl.cmd.disableStuck)
        disableReg <= 1'b1;
      if (ctrl.cmd.setFail) begin
        passReg <= 1'b0;
        failReg <= 1'b1;
      end else if (detect) begin
        passReg <= pcPass;
        failReg <= pcHitFail;
      end
    end
  end

  assign ctrl.passStatus    = passReg;
  assign ctrl.failStatus    = failReg;
  assign ctrl.stuckDisabled = disableReg;
  assign ctrl.detectPulse   = detectReg;

endmodule

//--- verilog/resetControl.sv
// Tile and core reset state with the post-detection sleep countdown
`timescale 1ns/1ps
`include "coreMon_macros.svh"

module resetControl (
  input  logic  dvtFlags,
  input  logic  pcFail,
  monCtrlIf.rst ctrl
);

  localparam int cntW = $clog2(`CM_SLEEP_DELAY);

  // Counted from the detection edge, detectPulse shows up one cycle later
  localparam logic [cntW-1:0] sleepLoad = cntW'(`CM_SLEEP_DELAY - 2);

  logic [cntW-1:0] sleepCnt;
  logic            sleepActive;
  logic            sleepDone;
  logic            tileResetReg;
  logic            coreResetReg;

  assign sleepDone = sleepActive & (sleepCnt == '0);

  // ------------------------------------------------------------
  // Sleep countdown
  // ------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      sleepActive <= 1'b0;
      sleepCnt    <= '0;
    end else if (ctrl.stuckDisabled) begin
      sleepActive <= 1'b0;                      // Checker off, core left running
    end else if (ctrl.detectPulse) begin
      sleepActive <= 1'b1;
      sleepCnt    <= sleepLoad;
    end else if (sleepDone) begin
      sleepActive <= 1'b0;
    end else if (sleepActive) begin
      sleepCnt <= sleepCnt - 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Reset state
  // ------------------------------------------------------------
  always_ff @(posedge dvtFlags or posedge pcFail) begin
    if (pcFail) begin
      tileResetReg <= 1'b1;                     // Held for program load
      coreResetReg <= 1'b0;
    end else begin
      if (sleepDone)
        coreResetReg <= 1'b1;

      // Explicit commands have the last word
      if (ctrl.cmd.forceTile)   tileResetReg <= 1'b1;
      if (ctrl.cmd.releaseTile) tileResetReg <= 1'b0;
      if (ctrl.cmd.forceCore)   coreResetReg <= 1'b1;
      if (ctrl.cmd.releaseCore) coreResetReg <= 1'b0;
    end
  end

  assign ctrl.tileReset = tileResetReg;
  assign ctrl.coreReset = coreResetReg;

endmodule
